// File: Bender.yml
package:
  name: ps2_host

sources:
  # packages first, then the blocks, top level last
  - hdl/ps2_pkg.sv
  - hdl/ps2_timing_pkg.sv
  - hdl/ps2_tick_gen.sv
  - hdl/ps2_line_rx.sv
  - hdl/ps2_line_tx.sv
  - hdl/ps2_init_seq.sv
  - hdl/ps2_host_top.sv
  - target: test
    files:
      - testbench/tb_ps2_host.sv

// File: filelist.f
hdl/ps2_pkg.sv
hdl/ps2_timing_pkg.sv
hdl/ps2_tick_gen.sv
hdl/ps2_line_rx.sv
hdl/ps2_line_tx.sv
hdl/ps2_init_seq.sv
hdl/ps2_host_top.sv
testbench/tb_ps2_host.sv

// File: hdl/ps2_host_top.sv
`default_nettype none

module ps2_host_top #(
	parameter int TICK_DIV = ps2_timing_pkg::TICK_DIV_DEFAULT
) (
	input  logic               qzt_clk,
	input  logic               rst_n,
	input  logic               trigger,
	input  logic               ps2_clk_in,
	input  logic               ps2_dat_in,
	output logic               ps2_clk_oe,
	output logic               ps2_dat_oe,
	output logic               busy,
	output logic               cmd_nack,
	output ps2_pkg::ps2_byte_t rx_byte,
	output logic               rx_valid,
	output logic               rx_err
);

	logic               tick;
	logic               tx_start;
	ps2_pkg::ps2_byte_t tx_byte;
	logic               tx_busy;
	logic               tx_done;
	logic               tx_nack;
	logic               rx_enable;

	// receiver deaf while host owns the line
	assign rx_enable = ~tx_busy;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	ps2_tick_gen #(.TICK_DIV(TICK_DIV)) i_tick_gen (
		.qzt_clk(qzt_clk), .rst_n(rst_n), .tick(tick)
	);

	ps2_line_rx i_line_rx (
		.qzt_clk(qzt_clk), .rst_n(rst_n), .tick(tick), .rx_enable(rx_enable),
		.ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .rx_err(rx_err), .rx_active()
	);

	ps2_line_tx i_line_tx (
		.qzt_clk(qzt_clk), .rst_n(rst_n), .tick(tick),
		.tx_start(tx_start), .tx_byte(tx_byte),
		.ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in),
		.ps2_clk_oe(ps2_clk_oe), .ps2_dat_oe(ps2_dat_oe),
		.tx_busy(tx_busy), .tx_done(tx_done), .tx_nack(tx_nack)
	);

	ps2_init_seq i_init_seq (
		.qzt_clk(qzt_clk), .rst_n(rst_n), .tick(tick), .trigger(trigger),
		.tx_busy(tx_busy), .tx_done(tx_done), .tx_nack(tx_nack), .rx_valid(rx_valid),
		.tx_start(tx_start), .tx_byte(tx_byte), .busy(busy), .cmd_nack(cmd_nack)
	);

endmodule

`default_nettype wire

// File: hdl/ps2_init_seq.sv
`default_nettype none

module ps2_init_seq (
	input  logic              qzt_clk,
	input  logic              rst_n,
	input  logic              tick,
	input  logic              trigger,
	input  logic              tx_busy,
	input  logic              tx_done,
	input  logic              tx_nack,
	input  logic              rx_valid,
	output logic              tx_start,
	output ps2_pkg::ps2_byte_t tx_byte,
	output logic              busy,
	output logic              cmd_nack
);

	ps2_pkg::seq_state_t         state;
	ps2_pkg::cmd_index_t         cmd_idx;
	ps2_timing_pkg::tick_count_t win_cnt;
	logic                        trig_q;
	logic                        trig_qq;
	logic                        trig_rise;

	// trigger sampled, edge seen one clock later
	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			trig_q <= 1'b0;
			trig_qq <= 1'b0;
		end else begin
			trig_q <= trigger;
			trig_qq <= trig_q;
		end
	end

	assign trig_rise = trig_q & ~trig_qq;

	////////////////////////////////////////
	// command lookup
	////////////////////////////////////////

	always_comb begin
		case (cmd_idx)
			2'd0: tx_byte = ps2_pkg::CMD_GET_ID;
			2'd1: tx_byte = ps2_pkg::CMD_STREAM;
			default: tx_byte = ps2_pkg::CMD_ENABLE;
		endcase
	end

	// start only when the transmitter is free
	assign tx_start = (state == ps2_pkg::SEND) && !tx_busy;
	assign busy = (state != ps2_pkg::IDLE);

	////////////////////////////////////////
	// sequencer FSM
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			state <= ps2_pkg::IDLE;
			cmd_idx <= '0;
			win_cnt <= '0;
			cmd_nack <= 1'b0;
		end else begin
			case (state)
				ps2_pkg::IDLE: begin
					// edges while busy never reach here
					if (trig_rise) begin
						cmd_idx <= '0;
						cmd_nack <= 1'b0;
						state <= ps2_pkg::SEND;
					end
				end
				ps2_pkg::SEND: begin
					if (!tx_busy) begin
						state <= ps2_pkg::WAIT_SENT;
					end
				end
				ps2_pkg::WAIT_SENT: begin
					// frame out, open response window
					if (tx_done) begin
						cmd_nack <= cmd_nack | tx_nack;
						win_cnt <= '0;
						state <= ps2_pkg::LISTEN;
					end
				end
				ps2_pkg::LISTEN: begin
					// first reply byte closes the window
					if (rx_valid) begin
						state <= ps2_pkg::NEXT;
					end else if (tick) begin
						if (win_cnt == ps2_timing_pkg::tick_count_t'(
								ps2_timing_pkg::RESP_TICKS - 1)) begin
							state <= ps2_pkg::NEXT;
						end else begin
							win_cnt <= win_cnt + 1'b1;
						end
					end
				end
				ps2_pkg::NEXT: begin
					if (cmd_idx == ps2_pkg::cmd_index_t'(ps2_pkg::NUM_CMDS - 1)) begin
						state <= ps2_pkg::IDLE;
					end else begin
						cmd_idx <= cmd_idx + 1'b1;
						state <= ps2_pkg::SEND;
					end
				end
				default: begin
					state <= ps2_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/ps2_line_rx.sv
`default_nettype none

module ps2_line_rx (
	input  logic              qzt_clk,
	input  logic              rst_n,
	input  logic              tick,
	input  logic              rx_enable,
	input  logic              ps2_clk_in,
	input  logic              ps2_dat_in,
	output ps2_pkg::ps2_byte_t rx_byte,
	output logic              rx_valid,
	output logic              rx_err,
	output logic              rx_active
);

	logic [1:0]          clk_sync;
	logic [1:0]          dat_sync;
	logic                clk_prev;
	logic                fall;
	ps2_pkg::ps2_frame_t frame;
	logic [3:0]          bit_cnt;
	logic [4:0]          idle_cnt;
	logic                frame_end;
	logic                frame_ok;

	////////////////////////////////////////
	// line sync and edge detect
	////////////////////////////////////////

	// two flops per line
	always_ff @(posedge qzt_clk) begin
		clk_sync <= {clk_sync[0], ps2_clk_in};
		dat_sync <= {dat_sync[0], ps2_dat_in};
	end

	// previous clock level, only updated on tick
	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			clk_prev <= 1'b1;
		end else if (tick) begin
			clk_prev <= clk_sync[1];
		end
	end

	// high to low between two ticks
	assign fall = tick & clk_prev & ~clk_sync[1];

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

	////////////////////////////////////////
	// frame shifter
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			rx_active <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			frame_end <= 1'b0;
			if (!rx_enable) begin
				// transmitter owns the line
				bit_cnt <= '0;
				idle_cnt <= '0;
				rx_active <= 1'b0;
			end else if (fall) begin
				// new bit goes in at the top, start bit ends up at bit 0
				frame <= {dat_sync[1], frame[10:1]};
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					rx_active <= 1'b0;
					frame_end <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					rx_active <= 1'b1;
				end
			end else if (tick && rx_active) begin
				// stuck frame, drop it after 32 quiet ticks
				if (idle_cnt == 5'd31) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
					rx_active <= 1'b0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// check and output
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
			rx_err <= 1'b0;
		end else begin
			rx_valid <= frame_end & frame_ok;
			rx_err <= frame_end & ~frame_ok;
		end
	end

	// byte held until the next good frame
	always_ff @(posedge qzt_clk) begin
		if (frame_end && frame_ok) begin
			rx_byte <= frame[8:1];
		end
	end

endmodule

`default_nettype wire

// File: hdl/ps2_line_tx.sv
`default_nettype none

module ps2_line_tx (
	input  logic              qzt_clk,
	input  logic              rst_n,
	input  logic              tick,
	input  logic              tx_start,
	input  ps2_pkg::ps2_byte_t tx_byte,
	input  logic              ps2_clk_in,
	input  logic              ps2_dat_in,
	output logic              ps2_clk_oe,
	output logic              ps2_dat_oe,
	output logic              tx_busy,
	output logic              tx_done,
	output logic              tx_nack
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_INHIBIT,
		TX_REQUEST,
		TX_SHIFT,
		TX_ACK,
		TX_DONE
	} tx_state_t;

	tx_state_t                   state;
	logic [1:0]                  clk_sync;
	logic [1:0]                  dat_sync;
	logic                        clk_prev;
	logic                        fall;
	logic [9:0]                  shift;
	logic [3:0]                  bit_cnt;
	ps2_timing_pkg::tick_count_t inh_cnt;
	logic                        nack;

	////////////////////////////////////////
	// own line sync
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		clk_sync <= {clk_sync[0], ps2_clk_in};
		dat_sync <= {dat_sync[0], ps2_dat_in};
	end

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			clk_prev <= 1'b1;
		end else if (tick) begin
			clk_prev <= clk_sync[1];
		end
	end

	// device clock falling, seen on tick
	assign fall = tick & clk_prev & ~clk_sync[1];

	////////////////////////////////////////
	// send FSM
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			ps2_clk_oe <= 1'b0;
			ps2_dat_oe <= 1'b0;
			bit_cnt <= '0;
			inh_cnt <= '0;
			nack <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						// stop, odd parity, data lsb first
						shift <= {1'b1, ~^tx_byte, tx_byte};
						inh_cnt <= '0;
						bit_cnt <= '0;
						ps2_clk_oe <= 1'b1;
						state <= TX_INHIBIT;
					end
				end
				TX_INHIBIT: begin
					// clock pulled low, count ticks
					if (tick) begin
						if (inh_cnt == ps2_timing_pkg::tick_count_t'(
								ps2_timing_pkg::INHIBIT_TICKS)) begin
							// release clock, data low is the start bit
							ps2_clk_oe <= 1'b0;
							ps2_dat_oe <= 1'b1;
							state <= TX_REQUEST;
						end else begin
							inh_cnt <= inh_cnt + 1'b1;
						end
					end
				end
				TX_REQUEST, TX_SHIFT: begin
					// next bit while device clock is low
					if (fall) begin
						ps2_dat_oe <= ~shift[0];
						shift <= {1'b1, shift[9:1]};
						bit_cnt <= bit_cnt + 1'b1;
						// tenth bit is the stop bit
						if (bit_cnt == 4'd9) begin
							state <= TX_ACK;
						end else begin
							state <= TX_SHIFT;
						end
					end
				end
				TX_ACK: begin
					// device should hold data low here
					if (fall) begin
						nack <= dat_sync[1];
						state <= TX_DONE;
					end
				end
				TX_DONE: begin
					state <= TX_IDLE;
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// status
	assign tx_busy = (state == TX_INHIBIT) || (state == TX_REQUEST) ||
		(state == TX_SHIFT) || (state == TX_ACK);
	assign tx_done = (state == TX_DONE);
	assign tx_nack = tx_done & nack;

endmodule

`default_nettype wire

// File: hdl/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

	////////////////////////////////////////
	// frame and byte widths
	////////////////////////////////////////

	// one data byte carried by a frame
	typedef logic [7:0] ps2_byte_t;

	// raw frame as it comes off the wire
	// bit 0 start, bits 8..1 data lsb first, bit 9 odd parity, bit 10 stop
	typedef logic [10:0] ps2_frame_t;

	// selects one entry of the command list
	typedef logic [1:0] cmd_index_t;

	////////////////////////////////////////
	// command list
	////////////////////////////////////////

	// length of the init list
	localparam int NUM_CMDS = 3;

	// read device id
	localparam ps2_byte_t CMD_GET_ID = 8'hF2;
	// set stream mode
	localparam ps2_byte_t CMD_STREAM = 8'hEA;
	// enable data reporting
	localparam ps2_byte_t CMD_ENABLE = 8'hF4;

	// device acknowledge byte
	localparam ps2_byte_t RESP_ACK = 8'hFA;

	// init sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SEND,
		WAIT_SENT,
		LISTEN,
		NEXT
	} seq_state_t;

endpackage

`default_nettype wire

// File: hdl/ps2_tick_gen.sv
`default_nettype none

module ps2_tick_gen #(
	parameter int TICK_DIV = ps2_timing_pkg::TICK_DIV_DEFAULT
) (
	input  logic qzt_clk,
	input  logic rst_n,
	output logic tick
);

	// counter width, at least one bit
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             wrap;

	// last count of the period
	assign wrap = (div_cnt == CNT_W'(TICK_DIV - 1));

	////////////////////////////////////////
	// divider
	////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else begin
			// back to zero at end of period
			if (wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			// one cycle strobe, used as clock enable everywhere
			tick <= wrap;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ps2_timing_pkg.sv
`default_nettype none

package ps2_timing_pkg;

	////////////////////////////////////////
	// sample tick
	////////////////////////////////////////

	// qzt_clk cycles per tick
	// 10 MHz in, 50 kHz out
	localparam int TICK_DIV_DEFAULT = 200;

	////////////////////////////////////////
	// line timing in ticks
	////////////////////////////////////////

	// clock held low before request to send
	// 6 ticks is 120 us at 50 kHz
	localparam int INHIBIT_TICKS = 6;

	// window for the device reply after each command
	localparam int RESP_TICKS = 350;

	// wide enough for RESP_TICKS
	typedef logic [9:0] tick_count_t;

endpackage

`default_nettype wire

// File: testbench/tb_ps2_host.sv
`default_nettype none

module tb_ps2_host;

	////////////////////////////////////////
	// constants
	////////////////////////////////////////

	localparam int TICK_DIV = 4;
	localparam int NUM_TESTS = 9;
	// time units per tick, qzt_clk period is 4
	localparam int TICK_TIME = TICK_DIV * 4;
	localparam int WD_TIME = NUM_TESTS * 3 * ps2_timing_pkg::RESP_TICKS * TICK_TIME;
	// cycles allowed for a request or for busy to fall
	localparam int MAX_WAIT = (ps2_timing_pkg::RESP_TICKS + 64) * TICK_DIV;

	logic               qzt_clk;
	logic               rst_n;
	logic               trigger;
	logic               ps2_clk_in;
	logic               ps2_dat_in;
	logic               ps2_clk_oe;
	logic               ps2_dat_oe;
	logic               busy;
	logic               cmd_nack;
	ps2_pkg::ps2_byte_t rx_byte;
	logic               rx_valid;
	logic               rx_err;

	// device side of the open-drain lines, 1 is released
	logic               dev_clk;
	logic               dev_dat;

	logic [31:0]        lcg_state;
	int                 half_ticks;
	int                 errors;
	int                 tests_run;
	int                 failed_tests;
	int                 test_start_errors;
	int                 err_seen;
	int                 err_exp;
	int                 req_seen;
	logic               clk_oe_q;
	ps2_pkg::ps2_byte_t mon_exp;
	// bytes the device sent with a good frame, oldest first
	ps2_pkg::ps2_byte_t exp_rx[$];

	// wired AND of pull-ups, device and host
	assign ps2_clk_in = dev_clk & ~ps2_clk_oe;
	assign ps2_dat_in = dev_dat & ~ps2_dat_oe;

	ps2_host_top #(.TICK_DIV(TICK_DIV)) i_ps2_host_top (
		.qzt_clk(qzt_clk), .rst_n(rst_n), .trigger(trigger),
		.ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in),
		.ps2_clk_oe(ps2_clk_oe), .ps2_dat_oe(ps2_dat_oe),
		.busy(busy), .cmd_nack(cmd_nack),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .rx_err(rx_err)
	);

	initial begin
		qzt_clk = 1'b0;
	end

	always #2 qzt_clk = ~qzt_clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// lcg step, value in lo..hi
	function automatic int rand_range(input int lo, input int hi);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lo + int'((lcg_state >> 8) % 32'(hi - lo + 1));
	endfunction

	// init list as the device should see it
	function automatic ps2_pkg::ps2_byte_t exp_cmd(input int c);
		case (c)
			0: return 8'hF2;
			1: return 8'hEA;
			default: return 8'hF4;
		endcase
	endfunction

	// ends one time unit after a rising edge
	task automatic wait_ticks(input int n);
		repeat (n * TICK_DIV) @(posedge qzt_clk);
		#1;
	endtask

	// for_idle 0 waits for a request to send, 1 for busy low
	task automatic wait_for_state(input bit for_idle, output bit ok);
		int n;
		n = 0;
		ok = 1'b0;
		while (!ok && n < MAX_WAIT) begin
			if (for_idle) begin
				ok = !busy;
			end else begin
				ok = ps2_clk_in && !ps2_dat_in;
			end
			if (!ok) begin
				@(posedge qzt_clk);
				#1;
				n++;
			end
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// device model
	////////////////////////////////////////

	// corrupt 1 flips parity, 2 sends a low stop bit
	task automatic send_frame(input ps2_pkg::ps2_byte_t b, input int corrupt);
		logic [10:0] bits;
		int          i;
		bits = {1'b1, ~^b, b, 1'b0};
		if (corrupt == 1) begin
			bits[9] = ~bits[9];
		end
		if (corrupt == 2) begin
			bits[10] = 1'b0;
		end
		if (corrupt == 0) begin
			exp_rx.push_back(b);
		end else begin
			err_exp++;
		end
		// data set while clock high, host reads it while low
		for (i = 0; i < 11; i++) begin
			dev_dat = bits[i];
			wait_ticks(half_ticks);
			dev_clk = 1'b0;
			wait_ticks(half_ticks);
			dev_clk = 1'b1;
		end
		dev_dat = 1'b1;
		wait_ticks(2 * half_ticks);
	endtask

	// clock in data, parity and stop, then the line ack clock
	task automatic receive_cmd(input bit ack, output ps2_pkg::ps2_byte_t b,
			output bit par_ok, output bit stop_ok);
		logic [9:0] bits;
		int         i;
		for (i = 0; i < 10; i++) begin
			wait_ticks(half_ticks);
			dev_clk = 1'b0;
			wait_ticks(half_ticks);
			// device reads on the rising edge
			bits[i] = ps2_dat_in;
			dev_clk = 1'b1;
		end
		dev_dat = ~ack;
		wait_ticks(half_ticks);
		dev_clk = 1'b0;
		wait_ticks(half_ticks);
		dev_clk = 1'b1;
		dev_dat = 1'b1;
		b = bits[7:0];
		par_ok = ^bits[8:0];
		stop_ok = bits[9];
	endtask

	// one init run, masks pick silent and unacknowledged commands
	task automatic run_sequence(input logic [2:0] silent, input logic [2:0] no_ack,
			input int n_extra, input bit retrigger);
		ps2_pkg::ps2_byte_t cmd;
		bit                 par_ok;
		bit                 stop_ok;
		bit                 found;
		int                 c;
		int                 k;
		int                 req_start;
		req_start = req_seen;
		trigger = 1'b1;
		// edge sampled on the next clock, idle left one clock after that
		@(posedge qzt_clk);
		#1;
		expect_bit("busy", busy, 1'b0);
		@(posedge qzt_clk);
		#1;
		expect_bit("busy", busy, 1'b1);
		for (c = 0; c < 3; c++) begin
			wait_for_state(1'b0, found);
			if (!found) begin
				$display("no request to send came for command %0d", c);
				errors++;
				break;
			end
			receive_cmd(!no_ack[c], cmd, par_ok, stop_ok);
			if (cmd !== exp_cmd(c)) begin
				$display("Mismatch tx_byte of command %0d: got 0x%h expected 0x%h",
					c, cmd, exp_cmd(c));
				errors++;
			end
			if (!par_ok || !stop_ok) begin
				$display("command %0d had a bad parity or stop bit", c);
				errors++;
			end
			if (retrigger && c == 0) begin
				// second edge lands mid sequence
				expect_bit("busy", busy, 1'b1);
				trigger = 1'b0;
				wait_ticks(2);
				trigger = 1'b1;
			end
			if (!silent[c] && !no_ack[c]) begin
				wait_ticks(rand_range(2, 17));
				send_frame(ps2_pkg::RESP_ACK, 0);
				// next command follows FA at once, so extras only after the last
				if (c == 2) begin
					for (k = 0; k < n_extra; k++) begin
						send_frame(ps2_pkg::ps2_byte_t'(rand_range(0, 255)), 0);
					end
				end
			end
		end
		trigger = 1'b0;
		wait_for_state(1'b1, found);
		if (!found) begin
			$display("busy stayed high after the last command");
			errors++;
		end
		// room for a stray request
		wait_ticks(20);
		if (req_seen - req_start != 3) begin
			$display("host made %0d requests to send instead of 3", req_seen - req_start);
			errors++;
		end
		expect_bit("cmd_nack", cmd_nack, |no_ack);
	endtask

	task automatic finish_test(input string name);
		if (exp_rx.size() != 0) begin
			$display("%0d sent bytes never arrived on rx_byte", exp_rx.size());
			errors++;
			exp_rx.delete();
		end
		if (err_seen != err_exp) begin
			$display("Mismatch rx_err count: got 0x%h expected 0x%h", err_seen, err_exp);
			errors++;
			err_exp = err_seen;
		end
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_start_errors);
		end
		test_start_errors = errors;
		half_ticks = rand_range(3, 6);
	endtask

	////////////////////////////////////////
	// output monitor
	////////////////////////////////////////

	// negedge, away from the DUT's register updates
	always @(negedge qzt_clk) begin
		if (rst_n) begin
			if (rx_valid) begin
				if (exp_rx.size() == 0) begin
					$display("rx_valid with byte 0x%h when no good frame was sent", rx_byte);
					errors++;
				end else begin
					mon_exp = exp_rx.pop_front();
					if (rx_byte !== mon_exp) begin
						$display("Mismatch rx_byte: got 0x%h expected 0x%h", rx_byte, mon_exp);
						errors++;
					end
				end
			end
			if (rx_err) begin
				err_seen++;
			end
			// each inhibit starts one command
			if (ps2_clk_oe && !clk_oe_q) begin
				req_seen++;
			end
			clk_oe_q = ps2_clk_oe;
		end
	end

	initial begin
		#(WD_TIME);
		$display("watchdog expired after %0d time units", WD_TIME);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	initial begin
		logic [2:0] mask;
		int         t;
		int         k;
		lcg_state = 32'he98ccce5;
		rst_n = 1'b0;
		trigger = 1'b0;
		dev_clk = 1'b1;
		dev_dat = 1'b1;
		errors = 0;
		tests_run = 0;
		failed_tests = 0;
		test_start_errors = 0;
		err_seen = 0;
		err_exp = 0;
		req_seen = 0;
		clk_oe_q = 1'b0;
		half_ticks = rand_range(3, 6);
		repeat (10) @(posedge qzt_clk);
		#1;
		rst_n = 1'b1;
		wait_ticks(2);
		expect_bit("ps2_clk_oe", ps2_clk_oe, 1'b0);
		expect_bit("ps2_dat_oe", ps2_dat_oe, 1'b0);
		expect_bit("busy", busy, 1'b0);
		expect_bit("rx_valid", rx_valid, 1'b0);
		expect_bit("rx_err", rx_err, 1'b0);
		expect_bit("cmd_nack", cmd_nack, 1'b0);
		finish_test("reset_values");
		// FA for each command, random id byte after the last
		run_sequence(3'b000, 3'b000, 1, 1'b0);
		finish_test("init_ack");
		for (t = 0; t < 3; t++) begin
			mask = '0;
			for (k = 0; k < 3; k++) begin
				mask[k] = (rand_range(0, 3) == 0);
			end
			run_sequence(mask, 3'b000, rand_range(0, 2), 1'b0);
			finish_test("random_replies");
		end
		// window runs out on one command
		run_sequence(3'b001 << rand_range(0, 2), 3'b000, 0, 1'b0);
		finish_test("silent_device");
		run_sequence(3'b000, 3'b001 << rand_range(0, 2), 0, 1'b0);
		finish_test("no_line_ack");
		// sequencer idle, one of each fault then random frames
		send_frame(ps2_pkg::ps2_byte_t'(rand_range(0, 255)), 1);
		send_frame(ps2_pkg::ps2_byte_t'(rand_range(0, 255)), 2);
		for (k = 0; k < 4; k++) begin
			send_frame(ps2_pkg::ps2_byte_t'(rand_range(0, 255)), rand_range(0, 2));
		end
		finish_test("bad_frames");
		// then stream bytes into an idle host
		run_sequence(3'b000, 3'b000, 0, 1'b1);
		for (k = 0; k < 3; k++) begin
			send_frame(ps2_pkg::ps2_byte_t'(rand_range(0, 255)), 0);
		end
		finish_test("busy_retrigger");
		$display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
